// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= cdw_tb
FILELIST  ?= sources.f
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: dv/cdw_asserts.sv
// Read port and result pulse protocol checks, bound into the walker top level by the testbench
`default_nettype none

module cdw_asserts (
    input logic                     clk_i,
    input logic                     rst_ni,
    input logic                     rd_req_o,
    input logic [cdw_pkg::PLEN-1:0] rd_addr_o,
    input logic                     rd_ready_i,
    input logic                     rd_rdy_o,
    input logic                     busy_o,
    input logic                     dc_update_o,
    input logic                     cdw_error_o
);

    int fail_cnt = 0;

    // Request and address hold until the memory takes them
    req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (rd_req_o && !rd_ready_i) |=> (rd_req_o && $stable(rd_addr_o)))
        else begin
            fail_cnt++;
            $error("rd_req_o dropped or rd_addr_o changed before acceptance");
        end

    one_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(dc_update_o && cdw_error_o))
        else begin
            fail_cnt++;
            $error("dc_update_o and cdw_error_o high in the same cycle");
        end

    // One-cycle pulse, then the walker is idle
    pulse_ends_walk: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (dc_update_o || cdw_error_o) |=> (!busy_o && !dc_update_o && !cdw_error_o))
        else begin
            fail_cnt++;
            $error("Result pulse not followed by an idle walker");
        end

    pulse_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (dc_update_o || cdw_error_o) |-> busy_o)
        else begin
            fail_cnt++;
            $error("Result pulse outside a walk");
        end

    busy_falls_on_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $fell(busy_o) |-> $past(dc_update_o || cdw_error_o))
        else begin
            fail_cnt++;
            $error("Walk ended without a result pulse");
        end

    // Quiet outputs while in reset
    reset_quiet: assert property (@(posedge clk_i)
        !rst_ni |-> (!busy_o && !rd_req_o && !rd_rdy_o && !dc_update_o && !cdw_error_o))
        else begin
            fail_cnt++;
            $error("Walker output high during reset");
        end

endmodule

`default_nettype wire

// File: dv/cdw_tb.sv
// Testbench for the device-context walker with a memory model, walk stimulus and result checks
`default_nettype none

module cdw_tb;
    import cdw_pkg::*;

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST;
    localparam logic [PPN_W-1:0] ROOT_PPN = 44'h100;

    // DUT inputs
    logic             clk_i       = 1'b0;
    logic             rst_ni      = 1'b0;
    logic             ddtc_miss_i = 1'b0;
    logic [DID_W-1:0] req_did_i   = '0;
    logic [PPN_W-1:0] ddtp_ppn_i  = ROOT_PPN;
    ddt_mode_e        ddtp_mode_i = MODE_OFF;
    logic             rd_ready_i  = 1'b0;
    logic             rd_valid_i  = 1'b0;
    logic [DW_W-1:0]  rd_data_i   = '0;
    logic             rd_last_i   = 1'b0;
    logic             rd_err_i    = 1'b0;
    // DUT outputs
    logic              rd_req_o;
    logic [PLEN-1:0]   rd_addr_o;
    logic [BEAT_W-1:0] rd_len_o;
    logic              rd_rdy_o;
    logic              busy_o;
    logic              dc_update_o;
    logic [DID_W-1:0]  up_did_o;
    dc_t               up_dc_o;
    logic              cdw_error_o;
    cause_e            cause_o;
    logic [PLEN-1:0]   bad_addr_o;

    // Sparse table memory and the expected walk result
    logic [DW_W-1:0]  mem [logic [PLEN-1:0]];
    logic             exp_update   = 1'b0;
    dc_t              exp_dc       = '0;
    logic [DID_W-1:0] exp_did      = '0;
    cause_e           exp_cause    = CAUSE_NONE;
    logic [PLEN-1:0]  exp_bad_addr = '0;
    logic [PLEN-1:0]  exp_addrs [0:2] = '{default: '0};
    int               leaf_idx     = 0;
    logic             err_en       = 1'b0;
    logic [PLEN-1:0]  err_addr     = '0;
    logic             bp_heavy     = 1'b0;

    // Memory model state
    logic [31:0]     rnd_q     = 32'heafe26a1;
    int              remain    = 0;
    int              gap       = 0;
    logic [PLEN-1:0] beat_addr = '0;
    int              req_idx   = 0;

    int err_cnt   = 0;
    int test_cnt  = 0;
    int cycle_cnt = 0;

    always #50 clk_i = ~clk_i;

    cdw_top UUT (.*);

    bind cdw_top cdw_asserts u_asserts (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Non-leaf entries are 8 bytes apart
    function automatic logic [PLEN-1:0] entry_addr(input logic [PPN_W-1:0] ppn,
                                                   input logic [8:0] idx);
        return {ppn, 12'h000} + {44'h0, idx, 3'b000};
    endfunction

    // Contexts are 64 bytes apart
    function automatic logic [PLEN-1:0] leaf_addr(input logic [PPN_W-1:0] ppn,
                                                  input logic [5:0] idx);
        return {ppn, 12'h000} + {44'h0, idx, 6'b000000};
    endfunction

    function automatic logic [DW_W-1:0] nl_entry(input logic [PPN_W-1:0] ppn);
        return {10'h000, ppn, 9'h000, 1'b1};
    endfunction

    // --------------------------------------------------
    // Memory model with random back-pressure
    // --------------------------------------------------
    always @(posedge clk_i) begin
        rnd_q = xorshift32(rnd_q);
        if (!rst_ni) begin
            rd_ready_i <= 1'b0;
            rd_valid_i <= 1'b0;
            remain = 0;
            req_idx <= 0;
        end else begin
            if (ddtc_miss_i) begin
                req_idx <= 0;
            end
            if (rd_valid_i && rd_rdy_o) begin
                remain = remain - 1;
                beat_addr = beat_addr + 56'd8;
            end
            // Accepted request, burst starts after 0 to 3 idle cycles
            if (rd_req_o && rd_ready_i) begin
                remain = int'(rd_len_o) + 1;
                beat_addr = rd_addr_o;
                gap = int'(rnd_q[5:4]);
                req_idx <= req_idx + 1;
            end
            rd_ready_i <= bp_heavy ? (rnd_q[0] & rnd_q[1]) : (rnd_q[0] | rnd_q[1]);
            if (remain > 0 && gap > 0) begin
                gap = gap - 1;
                rd_valid_i <= 1'b0;
            end else if (remain > 0 &&
                         (bp_heavy ? (rnd_q[8] & rnd_q[9]) : (rnd_q[8] | rnd_q[9]))) begin
                rd_valid_i <= 1'b1;
                rd_data_i  <= mem.exists(beat_addr) ? mem[beat_addr] : 64'h0;
                rd_last_i  <= (remain == 1);
                rd_err_i   <= err_en && (beat_addr == err_addr);
            end else begin
                rd_valid_i <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Result checks
    // --------------------------------------------------
    update_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dc_update_o |-> exp_update)
        else begin
            $display("Update pulse where the walk should have ended in an error");
            err_cnt++;
        end

    error_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cdw_error_o |-> !exp_update)
        else begin
            $display("Error pulse where the walk should have ended in an update");
            err_cnt++;
        end

    read_addr_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (rd_req_o && rd_ready_i) |-> (rd_addr_o == exp_addrs[req_idx]))
        else begin
            $display("** Error: rd_addr_o = %h, expected %h", $sampled(rd_addr_o),
                     exp_addrs[$sampled(req_idx)]);
            err_cnt++;
        end

    // One beat per table entry and four for the context
    read_len_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (rd_req_o && rd_ready_i) |-> (rd_len_o == ((req_idx == leaf_idx) ? 2'd3 : 2'd0)))
        else begin
            $display("** Error: rd_len_o = %h, expected %h", $sampled(rd_len_o),
                     ($sampled(req_idx) == leaf_idx) ? 2'd3 : 2'd0);
            err_cnt++;
        end

    context_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dc_update_o |-> (up_dc_o == exp_dc && up_did_o == exp_did))
        else begin
            $display("** Error: up_dc_o = %h, expected %h", $sampled(up_dc_o), exp_dc);
            $display("** Error: up_did_o = %h, expected %h", $sampled(up_did_o), exp_did);
            err_cnt++;
        end

    cause_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cdw_error_o |-> (cause_o == exp_cause && bad_addr_o == exp_bad_addr))
        else begin
            $display("** Error: cause_o = %h, expected %h", $sampled(cause_o), exp_cause);
            $display("** Error: bad_addr_o = %h, expected %h", $sampled(bad_addr_o),
                     exp_bad_addr);
            err_cnt++;
        end

    // Error comes only after the burst is fully drained
    error_after_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cdw_error_o |-> $past(rd_valid_i && rd_rdy_o && rd_last_i))
        else begin
            $display("Error pulse before the last beat of the burst was taken");
            err_cnt++;
        end

    // Table setup, expected result, miss strobe and wait for the result pulse
    task automatic run_walk(input string name, input ddt_mode_e mode,
                            input logic [DID_W-1:0] did, input logic nl_invalid,
                            input logic tc_rsvd, input logic bus_err, input logic heavy);
        logic [PPN_W-1:0] ppn;
        logic [PLEN-1:0]  addr;
        int               lvls;
        int               n;
        int               t0;
        int               errs_before;
        logic             got_update;
        logic             done;
        lvls = (mode == MODE_3LVL) ? 3 : ((mode == MODE_2LVL) ? 2 : 1);
        leaf_idx = lvls - 1;
        ppn = ROOT_PPN;
        mem.delete();
        exp_update   = 1'b1;
        exp_cause    = CAUSE_NONE;
        exp_bad_addr = '0;
        err_en       = 1'b0;
        bp_heavy     = heavy;
        // Each non-leaf entry points to the next table page
        for (n = 0; n < lvls - 1; n++) begin
            addr = (lvls - n == 3) ? entry_addr(ppn, did[23:15]) : entry_addr(ppn, did[14:6]);
            exp_addrs[n] = addr;
            ppn = ppn + 44'h111;
            mem[addr] = nl_entry(ppn);
            if (nl_invalid && n == 0) begin
                mem[addr]    = nl_entry(ppn) & 64'hFFFF_FFFF_FFFF_FFFE;
                exp_update   = 1'b0;
                exp_cause    = DDT_ENTRY_INVALID;
                exp_bad_addr = addr;
            end
        end
        addr = leaf_addr(ppn, did[5:0]);
        exp_addrs[lvls-1] = addr;
        exp_did        = did;
        exp_dc.tc      = {47'h0, tc_rsvd, 4'h0, 12'hFF1};
        exp_dc.iohgatp = {4'h8, 36'h0, did};
        exp_dc.ta      = {40'h0, did[11:0], 12'h000};
        exp_dc.fsc     = {4'h9, 36'h0, did};
        mem[addr]          = exp_dc.tc;
        mem[addr + 56'd8]  = exp_dc.iohgatp;
        mem[addr + 56'd16] = exp_dc.ta;
        mem[addr + 56'd24] = exp_dc.fsc;
        if (tc_rsvd) begin
            exp_update   = 1'b0;
            exp_cause    = DDT_ENTRY_MISCONFIGURED;
            exp_bad_addr = addr;
        end
        // Bus error on the iohgatp beat
        if (bus_err) begin
            err_en       = 1'b1;
            err_addr     = addr + 56'd8;
            exp_update   = 1'b0;
            exp_cause    = DDT_DATA_CORRUPTION;
            exp_bad_addr = addr;
        end
        errs_before = err_cnt + UUT.u_asserts.fail_cnt;
        @(posedge clk_i);
        ddtc_miss_i <= 1'b1;
        req_did_i   <= did;
        ddtp_mode_i <= mode;
        @(posedge clk_i);
        ddtc_miss_i <= 1'b0;
        t0 = cycle_cnt;
        done = 1'b0;
        got_update = 1'b0;
        while (!done) begin
            @(posedge clk_i);
            if (dc_update_o || cdw_error_o) begin
                done = 1'b1;
                got_update = dc_update_o;
            end
        end
        repeat (2) @(posedge clk_i);
        test_cnt++;
        $display("Test %0d %s: %s after %0d cycles, %s", test_cnt, name,
                 got_update ? "update" : "error", cycle_cnt - t0,
                 (err_cnt + UUT.u_asserts.fail_cnt == errs_before) ? "ok" : "FAILED");
    endtask

    // --------------------------------------------------
    // Timeout and test sequence
    // --------------------------------------------------
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: the walks did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;
        repeat (2) @(posedge clk_i);
        run_walk("one-level walk", MODE_1LVL, 24'h00_002A, 1'b0, 1'b0, 1'b0, 1'b0);
        run_walk("three-level walk", MODE_3LVL, 24'hB3_C6D5, 1'b0, 1'b0, 1'b0, 1'b0);
        run_walk("invalid non-leaf entry", MODE_2LVL, 24'h01_2345, 1'b1, 1'b0, 1'b0, 1'b0);
        run_walk("reserved bit in tc", MODE_1LVL, 24'h00_0011, 1'b0, 1'b1, 1'b0, 1'b0);
        run_walk("bus error on leaf beat", MODE_1LVL, 24'h00_0007, 1'b0, 1'b0, 1'b1, 1'b0);
        run_walk("two-level walk under back-pressure", MODE_2LVL, 24'h7F_FF3C,
                 1'b0, 1'b0, 1'b0, 1'b1);
        $display("Summary: %0d tests, %0d result errors, %0d protocol errors", test_cnt,
                 err_cnt, UUT.u_asserts.fail_cnt);
        if (err_cnt + UUT.u_asserts.fail_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/cdw_beat_counter.sv
// Counter of captured context doublewords, giving the store its index and the FSM its done flag
`default_nettype none

module cdw_beat_counter (
    input  logic    clk_i,
    input  logic    rst_ni,
    cdw_walk_if.cnt walk
);
    import cdw_pkg::*;

    logic [CNT_W-1:0] cnt_q;

    // Clear comes with the leaf request, capture with each leaf beat
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else if (walk.clear) begin
            cnt_q <= '0;
        end else if (walk.capture && !walk.loaded) begin
            cnt_q <= cnt_q + CNT_W'(1);
        end
    end

    // Low bits select the doubleword being received
    assign walk.beat_idx = cnt_q[BEAT_W-1:0];
    assign walk.loaded   = (cnt_q == CNT_W'(DC_DWS));

endmodule

`default_nettype wire

// File: logic/cdw_dc_store.sv
// Device context register that captures each leaf doubleword and checks its fields
`default_nettype none

module cdw_dc_store (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic [cdw_pkg::DW_W-1:0] rd_data_i,
    output cdw_pkg::dc_t             up_dc_o,
    cdw_walk_if.store                walk
);
    import cdw_pkg::*;

    dc_t dc_q;

    // iohgatp and fsc share the same mode set
    function automatic logic mode_ok(input logic [DW_W-1:0] dw);
        logic [MODE_W-1:0] mode;
        mode = dw[MODE_LSB +: MODE_W];
        return mode inside {ATP_BARE, ATP_SV39, ATP_SV48, ATP_SV57};
    endfunction

    // --------------------------------------------------
    // Field checks on the incoming beat
    // --------------------------------------------------
    always_comb begin
        walk.dc_fault = CAUSE_NONE;
        case (walk.beat_idx)
            DW_TC: begin
                if (!rd_data_i[TC_V_BIT]) begin
                    walk.dc_fault = DDT_ENTRY_INVALID;
                end else if (|(rd_data_i & TC_RSVD_MASK)) begin
                    walk.dc_fault = DDT_ENTRY_MISCONFIGURED;
                end
            end
            DW_IOHGATP: begin
                if (!mode_ok(rd_data_i)) begin
                    walk.dc_fault = DDT_ENTRY_MISCONFIGURED;
                end
            end
            DW_TA: begin
                if (|(rd_data_i & TA_RSVD_MASK)) begin
                    walk.dc_fault = DDT_ENTRY_MISCONFIGURED;
                end
            end
            DW_FSC: begin
                if ((|(rd_data_i & FSC_RSVD_MASK)) || !mode_ok(rd_data_i)) begin
                    walk.dc_fault = DDT_ENTRY_MISCONFIGURED;
                end
            end
            default: begin
                walk.dc_fault = CAUSE_NONE;
            end
        endcase
    end

    // --------------------------------------------------
    // Context register
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dc_q <= '0;
        end else if (walk.capture) begin
            case (walk.beat_idx)
                DW_TC:      dc_q.tc      <= rd_data_i;
                DW_IOHGATP: dc_q.iohgatp <= rd_data_i;
                DW_TA:      dc_q.ta      <= rd_data_i;
                default:    dc_q.fsc     <= rd_data_i;
            endcase
        end
    end

    assign up_dc_o = dc_q;

endmodule

`default_nettype wire

// File: logic/cdw_fsm.sv
// Walker FSM that sequences a directory miss through memory reads, checks and result pulses
`default_nettype none

module cdw_fsm (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       ddtc_miss_i,
    input  cdw_pkg::ddt_mode_e         ddtp_mode_i,
    // Read request
    output logic                       rd_req_o,
    output logic [cdw_pkg::BEAT_W-1:0] rd_len_o,
    input  logic                       rd_ready_i,
    // Read response
    input  logic                       rd_valid_i,
    input  logic                       rd_last_i,
    input  logic                       rd_err_i,
    output logic                       rd_rdy_o,
    // Walk status and result
    output logic                       busy_o,
    output logic                       dc_update_o,
    output logic                       cdw_error_o,
    output cdw_pkg::cause_e            cause_o,
    output logic                       err_addr_sel_o,
    cdw_walk_if.fsm                    walk
);
    import cdw_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        MEM_ACCESS,
        NON_LEAF,
        LEAF,
        DRAIN,
        ERROR
    } state_e;

    state_e state_q, state_n;
    cause_e cause_q, cause_n;
    // Fault seen on the beat now on the bus
    cause_e beat_cause;

    // Bus error wins over the field checks of the same beat
    always_comb begin
        if (rd_err_i) begin
            beat_cause = DDT_DATA_CORRUPTION;
        end else if (state_q == NON_LEAF) begin
            beat_cause = walk.nl_fault;
        end else begin
            beat_cause = walk.dc_fault;
        end
    end

    // --------------------------------------------------
    // Next state and strobes
    // --------------------------------------------------
    always_comb begin
        state_n      = state_q;
        cause_n      = cause_q;
        rd_req_o     = 1'b0;
        rd_rdy_o     = 1'b0;
        walk.start   = 1'b0;
        walk.step    = 1'b0;
        walk.capture = 1'b0;
        walk.clear   = 1'b0;

        case (state_q)
            IDLE: begin
                // Misses outside the table modes are ignored
                if (ddtc_miss_i && (ddtp_mode_i inside {MODE_1LVL, MODE_2LVL, MODE_3LVL})) begin
                    walk.start = 1'b1;
                    state_n    = MEM_ACCESS;
                end
            end

            MEM_ACCESS: begin
                rd_req_o = 1'b1;
                if (rd_ready_i) begin
                    if (walk.last_lvl) begin
                        // Leaf burst starts from doubleword 0
                        walk.clear = 1'b1;
                        state_n    = LEAF;
                    end else begin
                        state_n = NON_LEAF;
                    end
                end
            end

            NON_LEAF: begin
                rd_rdy_o = 1'b1;
                if (rd_valid_i) begin
                    if (beat_cause != CAUSE_NONE) begin
                        cause_n = beat_cause;
                        state_n = ERROR;
                    end else begin
                        walk.step = 1'b1;
                        state_n   = MEM_ACCESS;
                    end
                end
            end

            LEAF: begin
                if (walk.loaded) begin
                    // Context complete and clean
                    state_n = IDLE;
                end else begin
                    rd_rdy_o = 1'b1;
                    if (rd_valid_i) begin
                        walk.capture = 1'b1;
                        if (beat_cause != CAUSE_NONE) begin
                            cause_n = beat_cause;
                            // Early fault leaves beats in flight
                            state_n = rd_last_i ? ERROR : DRAIN;
                        end
                    end
                end
            end

            DRAIN: begin
                // Later faults are dropped, only the first one counts
                rd_rdy_o = 1'b1;
                if (rd_valid_i && rd_last_i) begin
                    state_n = ERROR;
                end
            end

            ERROR: begin
                state_n = IDLE;
            end

            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            cause_q <= CAUSE_NONE;
        end else begin
            state_q <= state_n;
            cause_q <= cause_n;
        end
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------
    assign busy_o         = (state_q != IDLE);
    // One beat per non-leaf entry, full context on the leaf
    assign rd_len_o       = walk.last_lvl ? LEAF_LEN : '0;
    assign dc_update_o    = (state_q == LEAF) && walk.loaded;
    assign cdw_error_o    = (state_q == ERROR);
    assign err_addr_sel_o = (state_q == ERROR);
    assign cause_o        = cause_q;

endmodule

`default_nettype wire

// File: logic/cdw_pkg.sv
// Shared widths, cause codes, encodings and context layout, imported by every walker block
`default_nettype none

package cdw_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int unsigned DID_W   = 24;
    localparam int unsigned PPN_W   = 44;
    localparam int unsigned PLEN    = 56;
    localparam int unsigned DW_W    = 64;
    localparam int unsigned CAUSE_W = 11;
    localparam int unsigned MODE_W  = 4;

    // Context length in doublewords, plus index and count widths
    localparam int unsigned DC_DWS = 4;
    localparam int unsigned BEAT_W = $clog2(DC_DWS);
    localparam int unsigned CNT_W  = $clog2(DC_DWS + 1);
    // Burst length field of a leaf read
    localparam logic [BEAT_W-1:0] LEAF_LEN = BEAT_W'(DC_DWS - 1);

    typedef enum logic [CAUSE_W-1:0] {
        CAUSE_NONE              = 11'd0,
        DDT_ENTRY_INVALID       = 11'd258,
        DDT_ENTRY_MISCONFIGURED = 11'd259,
        DDT_DATA_CORRUPTION     = 11'd268
    } cause_e;

    // Table mode from ddtp
    typedef enum logic [MODE_W-1:0] {
        MODE_OFF  = 4'd0,
        MODE_BARE = 4'd1,
        MODE_1LVL = 4'd2,
        MODE_2LVL = 4'd3,
        MODE_3LVL = 4'd4
    } ddt_mode_e;

    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } level_e;

    // --------------------------------------------------
    // Non-leaf entry layout
    // --------------------------------------------------
    localparam int unsigned NL_V_BIT   = 0;
    localparam int unsigned NL_PPN_LSB = 10;
    // Bits 63:54 and 9:1
    localparam logic [DW_W-1:0] NL_RSVD_MASK = 64'hFFC0_0000_0000_03FE;

    // Device ID slices per level and the pointer shift below them
    localparam int unsigned IDX3_LSB = 15;
    localparam int unsigned IDX2_LSB = 6;
    localparam int unsigned IDX1_W   = 6;
    localparam int unsigned NL_SHIFT = 3;
    localparam int unsigned DC_SHIFT = 6;
    localparam int unsigned NL_IDX_W = PLEN - PPN_W - NL_SHIFT;

    // --------------------------------------------------
    // Device context checks
    // --------------------------------------------------
    localparam int unsigned TC_V_BIT = 0;
    localparam logic [DW_W-1:0] TC_RSVD_MASK = 64'hFFFF_FFFF_FFFF_F000;
    // Mode field at the top of iohgatp and fsc
    localparam int unsigned MODE_LSB = 60;
    localparam logic [DW_W-1:0] FSC_RSVD_MASK = 64'h0FFF_F000_0000_0000;
    localparam logic [DW_W-1:0] TA_RSVD_MASK  = 64'hFFFF_FFFF_0000_0FFF;

    // Allowed iohgatp and fsc modes
    localparam logic [MODE_W-1:0] ATP_BARE = 4'd0;
    localparam logic [MODE_W-1:0] ATP_SV39 = 4'd8;
    localparam logic [MODE_W-1:0] ATP_SV48 = 4'd9;
    localparam logic [MODE_W-1:0] ATP_SV57 = 4'd10;

    // Doubleword order in the leaf burst
    localparam logic [BEAT_W-1:0] DW_TC      = 2'd0;
    localparam logic [BEAT_W-1:0] DW_IOHGATP = 2'd1;
    localparam logic [BEAT_W-1:0] DW_TA      = 2'd2;
    localparam logic [BEAT_W-1:0] DW_FSC     = 2'd3;

    typedef struct packed {
        logic [DW_W-1:0] tc;
        logic [DW_W-1:0] iohgatp;
        logic [DW_W-1:0] ta;
        logic [DW_W-1:0] fsc;
    } dc_t;

endpackage

`default_nettype wire

// File: logic/cdw_pointer_gen.sv
// Pointer, level and device ID register that forms each table address and checks non-leaf entries
`default_nettype none

module cdw_pointer_gen (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic [cdw_pkg::PPN_W-1:0] ddtp_ppn_i,
    input  cdw_pkg::ddt_mode_e        ddtp_mode_i,
    input  logic [cdw_pkg::DID_W-1:0] req_did_i,
    input  logic [cdw_pkg::DW_W-1:0]  rd_data_i,
    output logic [cdw_pkg::PLEN-1:0]  rd_addr_o,
    output logic [cdw_pkg::DID_W-1:0] up_did_o,
    cdw_walk_if.ptr                   walk
);
    import cdw_pkg::*;

    level_e            lvl_q, lvl_n;
    level_e            start_lvl;
    logic [PLEN-1:0]   ptr_q, ptr_n;
    logic [DID_W-1:0]  did_q;
    logic [PPN_W-1:0]  nl_ppn;

    // Table base plus the ID slice of the level
    function automatic logic [PLEN-1:0] form_ptr(input logic [PPN_W-1:0] ppn,
                                                 input logic [DID_W-1:0] did,
                                                 input level_e lvl);
        logic [PLEN-1:0] ptr;
        case (lvl)
            LVL3:    ptr = {ppn, did[IDX3_LSB +: NL_IDX_W], {NL_SHIFT{1'b0}}};
            LVL2:    ptr = {ppn, did[IDX2_LSB +: NL_IDX_W], {NL_SHIFT{1'b0}}};
            // Leaf contexts are 64 bytes apart
            default: ptr = {ppn, did[IDX1_W-1:0], {DC_SHIFT{1'b0}}};
        endcase
        return ptr;
    endfunction

    // First level from the table mode
    always_comb begin
        case (ddtp_mode_i)
            MODE_3LVL: start_lvl = LVL3;
            MODE_2LVL: start_lvl = LVL2;
            default:   start_lvl = LVL1;
        endcase
    end

    assign nl_ppn = rd_data_i[NL_PPN_LSB +: PPN_W];

    always_comb begin
        lvl_n = lvl_q;
        ptr_n = ptr_q;
        if (walk.start) begin
            lvl_n = start_lvl;
            ptr_n = form_ptr(ddtp_ppn_i, req_did_i, start_lvl);
        end else if (walk.step) begin
            // Descend one level through the entry's PPN
            lvl_n = (lvl_q == LVL3) ? LVL2 : LVL1;
            ptr_n = form_ptr(nl_ppn, did_q, lvl_n);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lvl_q <= LVL1;
        end else begin
            lvl_q <= lvl_n;
        end
    end

    always_ff @(posedge clk_i) begin
        ptr_q <= ptr_n;
        if (walk.start) begin
            did_q <= req_did_i;
        end
    end

    // Invalid entry reported before reserved bits
    always_comb begin
        if (!rd_data_i[NL_V_BIT]) begin
            walk.nl_fault = DDT_ENTRY_INVALID;
        end else if (|(rd_data_i & NL_RSVD_MASK)) begin
            walk.nl_fault = DDT_ENTRY_MISCONFIGURED;
        end else begin
            walk.nl_fault = CAUSE_NONE;
        end
    end

    assign walk.last_lvl = (lvl_q == LVL1);
    assign rd_addr_o     = ptr_q;
    assign up_did_o      = did_q;

endmodule

`default_nettype wire

// File: logic/cdw_top.sv
// Device-context walker top level, joining the FSM, beat counter and data blocks to a plain read port
`default_nettype none

module cdw_top (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // Miss and table configuration
    input  logic                       ddtc_miss_i,
    input  logic [cdw_pkg::DID_W-1:0]  req_did_i,
    input  logic [cdw_pkg::PPN_W-1:0]  ddtp_ppn_i,
    input  cdw_pkg::ddt_mode_e         ddtp_mode_i,
    // Memory read port
    output logic                       rd_req_o,
    output logic [cdw_pkg::PLEN-1:0]   rd_addr_o,
    output logic [cdw_pkg::BEAT_W-1:0] rd_len_o,
    input  logic                       rd_ready_i,
    input  logic                       rd_valid_i,
    input  logic [cdw_pkg::DW_W-1:0]   rd_data_i,
    input  logic                       rd_last_i,
    input  logic                       rd_err_i,
    output logic                       rd_rdy_o,
    // Walk result
    output logic                       busy_o,
    output logic                       dc_update_o,
    output logic [cdw_pkg::DID_W-1:0]  up_did_o,
    output cdw_pkg::dc_t               up_dc_o,
    output logic                       cdw_error_o,
    output cdw_pkg::cause_e            cause_o,
    output logic [cdw_pkg::PLEN-1:0]   bad_addr_o
);

    logic err_addr_sel;

    cdw_walk_if walk ();

    cdw_fsm u_fsm (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .ddtc_miss_i    (ddtc_miss_i),
        .ddtp_mode_i    (ddtp_mode_i),
        .rd_req_o       (rd_req_o),
        .rd_len_o       (rd_len_o),
        .rd_ready_i     (rd_ready_i),
        .rd_valid_i     (rd_valid_i),
        .rd_last_i      (rd_last_i),
        .rd_err_i       (rd_err_i),
        .rd_rdy_o       (rd_rdy_o),
        .busy_o         (busy_o),
        .dc_update_o    (dc_update_o),
        .cdw_error_o    (cdw_error_o),
        .cause_o        (cause_o),
        .err_addr_sel_o (err_addr_sel),
        .walk           (walk.fsm)
    );

    cdw_beat_counter u_beat_counter (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .walk   (walk.cnt)
    );

    cdw_pointer_gen u_pointer_gen (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .ddtp_ppn_i  (ddtp_ppn_i),
        .ddtp_mode_i (ddtp_mode_i),
        .req_did_i   (req_did_i),
        .rd_data_i   (rd_data_i),
        .rd_addr_o   (rd_addr_o),
        .up_did_o    (up_did_o),
        .walk        (walk.ptr)
    );

    cdw_dc_store u_dc_store (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .rd_data_i (rd_data_i),
        .up_dc_o   (up_dc_o),
        .walk      (walk.store)
    );

    // Faulting read pointer, shown only with the error pulse
    assign bad_addr_o = err_addr_sel ? rd_addr_o : '0;

endmodule

`default_nettype wire

// File: logic/cdw_walk_if.sv
// Walk controls and statuses shared by the walker FSM, counter, pointer and context blocks
`default_nettype none

interface cdw_walk_if;
    import cdw_pkg::*;

    // Pulses from the FSM
    logic start;
    logic step;
    logic capture;
    logic clear;

    // Pointer state and non-leaf check
    logic   last_lvl;
    cause_e nl_fault;

    // Context check on the current beat
    cause_e dc_fault;

    // Leaf beat position
    logic [BEAT_W-1:0] beat_idx;
    logic              loaded;

    modport fsm (output start, step, capture, clear,
                 input  last_lvl, nl_fault, dc_fault, loaded);
    modport ptr (input  start, step,
                 output last_lvl, nl_fault);
    modport cnt (input  capture, clear,
                 output beat_idx, loaded);
    modport store (input  capture, beat_idx,
                   output dc_fault);

endinterface

`default_nettype wire

// File: sources.f
logic/cdw_pkg.sv
logic/cdw_walk_if.sv
logic/cdw_fsm.sv
logic/cdw_beat_counter.sv
logic/cdw_pointer_gen.sv
logic/cdw_dc_store.sv
logic/cdw_top.sv
dv/cdw_asserts.sv
dv/cdw_tb.sv
